/* testbench/fetch_predict_testdata.txt */
# T name | U pc outcomes(bit i = update i) target count
# Q pc fetch_en expected_next_pc | S cycles fetch_en expected_final_pc (all hex)
T reset_state
S 00000002 0 00000000
Q 00000100 0 00000104
Q 0000007c 0 00000080
T taken_saturate
U 00000020 ffffffff 00000200 6
Q 00000020 0 00000024
U 00000020 ffffffff 00000200 1
Q 00000020 0 00000200
U 00000020 ffffffff 00000200 3
U 00000020 00000000 00000000 2
Q 00000020 0 00000024
T alternating
U 00000044 55555555 00000300 a
Q 00000044 0 00000300
U 00000044 00000001 00000300 1
Q 00000044 0 00000048
T target_replace
U 00000044 00000000 00000999 1
Q 00000044 0 00000300
U 00000044 00000001 00000700 1
U 00000044 00000000 00000999 1
Q 00000044 0 00000700
T step_fetch
Q 00000038 1 0000003c
S 00000004 1 00000700
S 00000002 0 00000700
S 00000002 1 00000708
T alias_index
Q 000000c4 0 00000700
U 000000c4 00000001 00000800 1
U 000000c4 00000000 00000000 1
Q 00000044 0 00000800

/* all.f */
+incdir+rtl
rtl/bp_pkg.sv
rtl/bp_table.sv
rtl/local_history_predictor.sv
rtl/fetch_pc_gen.sv
rtl/fetch_predict_top.sv
testbench/fetch_predict_properties.sv
testbench/tb_fetch_predict.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fetch_predict
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Test OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* testbench/tb_fetch_predict.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bp_params.svh"

module tb_fetch_predict import bp_pkg::*; ();

    localparam int    NUM_BRANCH   = 2 ** `BP_WIDTH_PC;
    localparam int    NUM_COUNTER  = 2 ** (`BP_WIDTH_PC + `BP_WIDTH_HIST);
    localparam int    RESET_CYCLES = 16;
    localparam int    MAX_REC      = 64;
    localparam string DATA_FILE    = "testbench/fetch_predict_testdata.txt";

    logic       clk = 1'b0;
    logic       rst_n;
    logic       fetch_en;
    logic       redirect;
    pc_t        redirect_pc;
    bp_update_t update;
    pc_t        pc;
    pc_t        next_pc;

    hist_t    m_hist [NUM_BRANCH];              // Reference model of the tables
    counter_t m_ctr  [NUM_COUNTER];
    pc_t      m_tgt  [NUM_BRANCH];
    pc_t      m_pc;                             // Expected fetch address

    logic [7:0]  rec_op   [MAX_REC];            // Records as read from the data file
    logic [31:0] rec_a    [MAX_REC];
    logic [31:0] rec_b    [MAX_REC];
    logic [31:0] rec_c    [MAX_REC];
    logic [31:0] rec_d    [MAX_REC];
    string       rec_name [MAX_REC];
    int          num_rec = 0;

    string test_name   = "";
    int    errors      = 0;
    int    checks      = 0;
    int    tests_run   = 0;
    int    test_errors = 0;
    int    test_checks = 0;
    int    asrt_fails  = 0;
    int    cycle_count = 0;
    int    cycle_limit = 1000000;               // Replaced once the records are counted
    bit    load_ok;

    always #2 clk = ~clk;                       // 4 ns period

    fetch_predict_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_en    (fetch_en),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .update      (update),
        .pc          (pc),
        .next_pc     (next_pc)
    );

    // Watchdog on clock cycles
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run went past %0d clock cycles", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic bp_idx_t branch_index(pc_t a);
        return a[`BP_WIDTH_PC+1:2];             // Word index, no tag
    endfunction

    function automatic bp_ctr_idx_t counter_index(pc_t a);
        return {m_hist[branch_index(a)], branch_index(a)};
    endfunction

    // Counter at 2 or 3 means taken
    function automatic pc_t model_predict(pc_t a);
        if (m_ctr[counter_index(a)] >= 2'd2) begin
            return m_tgt[branch_index(a)];
        end
        return a + 32'd4;
    endfunction

    function automatic void model_train(pc_t a, logic taken, pc_t tgt);
        bp_idx_t     bi;
        bp_ctr_idx_t ci;
        bi = branch_index(a);
        ci = counter_index(a);                  // Old history selects the counter
        if (taken && m_ctr[ci] != 2'd3) begin
            m_ctr[ci] = m_ctr[ci] + 2'd1;
        end else if (!taken && m_ctr[ci] != 2'd0) begin
            m_ctr[ci] = m_ctr[ci] - 2'd1;
        end
        m_hist[bi] = {m_hist[bi][`BP_WIDTH_HIST-2:0], taken};
        if (taken) begin
            m_tgt[bi] = tgt;                    // Not-taken keeps the old target
        end
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        test_checks++;
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic wait_edge();
        @(posedge clk);
        #1;                                     // Drive point after the edge
    endtask

    task automatic end_test();
        if (test_name != "") begin
            tests_run++;
            $display("test %s: %s (%0d checks, %0d errors)", test_name,
                     (test_errors == 0) ? "passed" : "failed", test_checks, test_errors);
        end
        test_errors = 0;
        test_checks = 0;
    endtask

    // Read all records and add up the cycles they take
    task automatic load_records(output bit ok);
        int          fd;
        int          n;
        int          total;
        string       line;
        logic [31:0] a0, a1, a2, a3;
        ok    = 1'b1;
        total = 0;
        fd    = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the data file %s", DATA_FILE);
            ok = 1'b0;
        end else begin
            while (!$feof(fd) && ok && num_rec < MAX_REC) begin
                line = "";
                n    = $fgets(line, fd);
                while (line.len() > 0 && line.getc(line.len() - 1) inside {8'h0a, 8'h0d}) begin
                    line = line.substr(0, line.len() - 2);
                end
                if (line.len() > 2 && line.getc(0) != "#") begin
                    a0 = '0;
                    a1 = '0;
                    a2 = '0;
                    a3 = '0;
                    rec_op[num_rec]   = line.getc(0);
                    rec_name[num_rec] = line.substr(2, line.len() - 1);
                    n = $sscanf(rec_name[num_rec], "%h %h %h %h", a0, a1, a2, a3);
                    rec_a[num_rec] = a0;
                    rec_b[num_rec] = a1;
                    rec_c[num_rec] = a2;
                    rec_d[num_rec] = a3;
                    case (rec_op[num_rec])
                        "T": ;
                        "U": total += int'(a3);
                        "Q": total += 1;
                        "S": total += int'(a0);
                        default: begin
                            $display("Unknown record in the data file: %s", line);
                            ok = 1'b0;
                        end
                    endcase
                    num_rec++;
                end
            end
            $fclose(fd);
        end
        cycle_limit = 2 * total + RESET_CYCLES + 2;
    endtask

    task automatic do_update(input pc_t a, input logic [31:0] outcomes, input pc_t tgt,
                             input int count);
        for (int i = 0; i < count; i++) begin
            update = '{valid: 1'b1, pc: a, taken: outcomes[i], target: tgt};
            wait_edge();
            model_train(a, outcomes[i], tgt);   // Write landed at that edge
        end
        update = '0;
    endtask

    task automatic do_query(input pc_t a, input logic fe, input pc_t exp);
        redirect    = 1'b1;
        redirect_pc = a;
        fetch_en    = fe;                       // Redirect must win when set
        wait_edge();
        redirect = 1'b0;
        fetch_en = 1'b0;
        m_pc     = a;
        check(pc, a, "pc after redirect");
        check(exp, model_predict(a), "data file next_pc against model");
        check(next_pc, model_predict(a), "next_pc");
    endtask

    task automatic do_step(input int count, input logic fe, input pc_t exp);
        for (int i = 0; i < count; i++) begin
            fetch_en = fe;
            if (fe) begin
                m_pc = model_predict(m_pc);
            end
            wait_edge();
            check(pc, m_pc, "pc while stepping");
        end
        fetch_en = 1'b0;
        check(exp, m_pc, "data file final pc against model");
    endtask

    task automatic run_record(input int i);
        case (rec_op[i])
            "T": begin
                end_test();
                test_name = rec_name[i];
            end
            "U": do_update(rec_a[i], rec_b[i], rec_c[i], int'(rec_d[i]));
            "Q": do_query(rec_a[i], rec_b[i][0], rec_c[i]);
            default: do_step(int'(rec_a[i]), rec_b[i][0], rec_c[i]);
        endcase
    endtask

    initial begin
        rst_n       = 1'b0;
        fetch_en    = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        update      = '0;
        m_pc        = `BP_RESET_PC;
        foreach (m_hist[i]) begin
            m_hist[i] = '0;
            m_tgt[i]  = '0;
        end
        foreach (m_ctr[i]) begin
            m_ctr[i] = '0;
        end
        load_records(load_ok);
        if (!load_ok) begin
            $display("The test data could not be loaded, no test was run");
            $display("Test FAILED");
            $finish;
        end else begin
            repeat (RESET_CYCLES) @(posedge clk);
            #1;
            rst_n = 1'b1;
            for (int i = 0; i < num_rec; i++) begin
                run_record(i);
            end
            end_test();
            asrt_fails = int'(DUT.u_props.redirect_fails + DUT.u_props.hold_fails
                              + DUT.u_props.target_fails);
            $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                     tests_run, checks, errors, asrt_fails);
            if (errors == 0 && asrt_fails == 0) begin
                $display("Test OK");
            end else begin
                $display("Test FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* testbench/fetch_predict_properties.sv */
`timescale 1ns/1ps
`default_nettype none

// Checks on the fetch front end, bound into the top level
module fetch_predict_properties import bp_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       fetch_en,
    input logic       redirect,
    input pc_t        redirect_pc,
    input bp_update_t update,
    input pc_t        pc,
    input pc_t        next_pc
);

    localparam int MAX_TARGETS = 64;

    pc_t         seen_tgt [MAX_TARGETS];        // Targets written so far
    int          num_seen;
    logic        tgt_known;
    int unsigned redirect_fails = 0;
    int unsigned hold_fails     = 0;
    int unsigned target_fails   = 0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            num_seen <= 0;
        end else if (update.valid && update.taken && num_seen < MAX_TARGETS) begin
            seen_tgt[num_seen] <= update.target;    // Only taken updates write a target
            num_seen           <= num_seen + 1;
        end
    end

    always_comb begin
        tgt_known = 1'b0;
        for (int i = 0; i < MAX_TARGETS; i++) begin
            if (i < num_seen && seen_tgt[i] == next_pc) begin
                tgt_known = 1'b1;
            end
        end
    end

    redirect_loads: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |=> pc == $past(redirect_pc))
        else begin
            $error("pc did not take redirect_pc");
            redirect_fails++;
        end

    stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
        !fetch_en && !redirect |=> pc == $past(pc))
        else begin
            $error("pc moved while stalled");
            hold_fails++;
        end

    next_pc_legal: assert property (@(posedge clk) disable iff (!rst_n)
        next_pc == pc + 32'd4 || tgt_known)
        else begin
            $error("next_pc is neither pc + 4 nor a trained target");
            target_fails++;
        end

endmodule

bind fetch_predict_top fetch_predict_properties u_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_en    (fetch_en),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .update      (update),
    .pc          (pc),
    .next_pc     (next_pc)
);

`default_nettype wire

/* rtl/fetch_predict_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Fetch front end
// The pc register feeds the predictor, whose next_pc feeds back in
module fetch_predict_top import bp_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       fetch_en,
    input  logic       redirect,
    input  pc_t        redirect_pc,
    input  bp_update_t update,
    output pc_t        pc,
    output pc_t        next_pc
);

    fetch_pc_gen u_pc_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_en    (fetch_en),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .next_pc     (next_pc),       // Closes the fetch loop
        .pc          (pc)
    );

    local_history_predictor u_predictor (
        .clk     (clk),
        .rst_n   (rst_n),
        .pc      (pc),
        .next_pc (next_pc),
        .update  (update)
    );

endmodule

`default_nettype wire

/* rtl/fetch_pc_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bp_params.svh"

// Fetch address register
// Redirect beats advance, fetch_en low stalls
module fetch_pc_gen import bp_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic fetch_en,      // Level, low holds pc
    input  logic redirect,      // One-cycle strobe
    input  pc_t  redirect_pc,   // Corrected address
    input  pc_t  next_pc,       // Prediction for the current pc
    output pc_t  pc
);

    pc_t pc_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= `BP_RESET_PC;
        end else if (redirect) begin
            pc_q <= redirect_pc;                    // Loads even while stalled
        end else if (fetch_en) begin
            pc_q <= next_pc;                        // Follow the predictor
        end
        // Otherwise hold
    end

    assign pc = pc_q;

endmodule

`default_nettype wire

/* rtl/local_history_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bp_params.svh"

// Local-history branch predictor
// branch index -> history, {history, index} -> counter, index -> target
module local_history_predictor import bp_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  pc_t        pc,          // Current fetch address
    output pc_t        next_pc,     // Predicted next fetch address
    input  bp_update_t update       // Retire-side training
);

    localparam int NUM_BRANCH  = 2 ** `BP_WIDTH_PC;
    localparam int NUM_COUNTER = 2 ** (`BP_WIDTH_PC + `BP_WIDTH_HIST);

    // Fetch side
    bp_idx_t     fetch_idx;
    hist_t       fetch_hist;
    bp_ctr_idx_t fetch_ctr_idx;
    counter_t    fetch_ctr;
    pc_t         fetch_target;
    pc_t         pc_plus4;

    // Update side
    bp_idx_t     upd_idx;
    hist_t       upd_hist;
    hist_t       upd_hist_next;
    bp_ctr_idx_t upd_ctr_idx;
    counter_t    upd_ctr;
    counter_t    upd_ctr_next;
    logic        target_we;

    // Word index with the byte offset bits dropped
    // Pcs that differ only above these bits alias because there is no tag
    assign fetch_idx = pc[`BP_WIDTH_PC+1:2];
    assign upd_idx   = update.pc[`BP_WIDTH_PC+1:2];

    assign fetch_ctr_idx = {fetch_hist, fetch_idx};
    assign upd_ctr_idx   = {upd_hist, upd_idx};

    // Per-branch history
    bp_table #(
        .entry_t     (hist_t),
        .DEPTH       (NUM_BRANCH),
        .RESET_VALUE (hist_t'(0))
    ) u_hist_table (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_a (fetch_idx),
        .rd_data_a (fetch_hist),
        .rd_addr_b (upd_idx),
        .rd_data_b (upd_hist),
        .wr_en     (update.valid),              // Every update shifts in its outcome
        .wr_addr   (upd_idx),
        .wr_data   (upd_hist_next)
    );

    // Pattern table of 2-bit counters
    bp_table #(
        .entry_t     (counter_t),
        .DEPTH       (NUM_COUNTER),
        .RESET_VALUE (CTR_MIN)
    ) u_ctr_table (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_a (fetch_ctr_idx),
        .rd_data_a (fetch_ctr),
        .rd_addr_b (upd_ctr_idx),
        .rd_data_b (upd_ctr),
        .wr_en     (update.valid),
        .wr_addr   (upd_ctr_idx),
        .wr_data   (upd_ctr_next)
    );

    // Branch targets
    bp_table #(
        .entry_t     (pc_t),
        .DEPTH       (NUM_BRANCH),
        .RESET_VALUE (pc_t'(0))
    ) u_target_table (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_a (fetch_idx),
        .rd_data_a (fetch_target),
        .rd_addr_b (upd_idx),
        .rd_data_b (),
        .wr_en     (target_we),
        .wr_addr   (upd_idx),
        .wr_data   (update.target)
    );

    // Training values
    assign upd_hist_next = {upd_hist[`BP_WIDTH_HIST-2:0], update.taken};
    assign upd_ctr_next  = ctr_step(upd_ctr, update.taken);

    // Only taken updates carry a target
    assign target_we = update.valid && update.taken;

    // Prediction is fully combinational
    assign pc_plus4 = pc + 32'd4;
    assign next_pc  = fetch_ctr[1] ? fetch_target : pc_plus4;   // Upper bit means taken

endmodule

`default_nettype wire

/* rtl/bp_table.sv */
`timescale 1ns/1ps
`default_nettype none

// Generic register-array table
// Two combinational read ports (prediction side and update side) plus one write port
module bp_table #(
    parameter type    entry_t     = logic [31:0],
    parameter int     DEPTH       = 32,
    parameter entry_t RESET_VALUE = entry_t'(0)
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [$clog2(DEPTH)-1:0] rd_addr_a,   // Prediction lookup
    output entry_t                   rd_data_a,
    input  logic [$clog2(DEPTH)-1:0] rd_addr_b,   // Update lookup
    output entry_t                   rd_data_b,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  entry_t                   wr_data
);

    entry_t mem [DEPTH];

    // Every entry clears to RESET_VALUE on reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= RESET_VALUE;
            end
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;                // Visible to reads next cycle
        end
    end

    // Reads are plain array lookups
    // A read in the write cycle returns the old entry
    assign rd_data_a = mem[rd_addr_a];
    assign rd_data_b = mem[rd_addr_b];

endmodule

`default_nettype wire

/* rtl/bp_pkg.sv */
`default_nettype none

package bp_pkg;

`include "bp_params.svh"

    typedef logic [31:0] pc_t;                              // Byte address
    typedef logic [`BP_WIDTH_HIST-1:0] hist_t;              // Newest outcome in bit 0
    typedef logic [1:0] counter_t;                          // 2-bit saturating counter

    // Index into the per-branch tables (history, target)
    typedef logic [`BP_WIDTH_PC-1:0] bp_idx_t;

    // Index into the counter table, history above branch index
    typedef logic [`BP_WIDTH_HIST+`BP_WIDTH_PC-1:0] bp_ctr_idx_t;

    localparam counter_t CTR_MIN = 2'b00;                   // Strongly not taken
    localparam counter_t CTR_MAX = 2'b11;                   // Strongly taken

    // Retire-side training bundle
    typedef struct packed {
        logic valid;                                        // One-cycle strobe
        pc_t  pc;                                           // Branch address
        logic taken;                                        // Resolved outcome
        pc_t  target;                                       // Resolved target
    } bp_update_t;

    // Step a counter toward the outcome, sticking at both ends
    function automatic counter_t ctr_step(counter_t cur, logic taken);
        counter_t nxt;
        nxt = cur;
        if (taken && cur != CTR_MAX) begin
            nxt = cur + 2'd1;
        end else if (!taken && cur != CTR_MIN) begin
            nxt = cur - 2'd1;
        end
        return nxt;
    endfunction

endpackage

`default_nettype wire

/* rtl/bp_params.svh */
`ifndef BP_PARAMS_SVH
`define BP_PARAMS_SVH

// Word-index bits of the pc, taken from bit 2 upward
// 5 bits give 32 branch entries (history and target tables)
`define BP_WIDTH_PC 5

// Local history length per branch entry
// Counter table depth is 2 ** (BP_WIDTH_PC + BP_WIDTH_HIST)
`define BP_WIDTH_HIST 5

// Fetch address right after reset
`define BP_RESET_PC 32'h0000_0000

`endif
